/* fc_addr_ctl.f */
rtl/fc_addr_pkg.sv
rtl/settle_timer.sv
rtl/fc_layer_walker.sv
rtl/sram_addr_gen.sv
rtl/fc_addr_ctl.sv
verif/fc_addr_ctl_checker.sv
verif/fc_addr_ctl_tb.sv

/* rtl/fc_addr_ctl.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_addr_ctl import fc_addr_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          layer_state_t state,
    output act_port_t    act_port0,
    output sram_addr_t   act_addr1,
    output sram_addr_t   weight_addr0,
    output sram_addr_t   weight_addr1,
    output logic [4:0]   write_count,
    output logic [2:0]   store_case,
    output logic         change_state
);

    timer_ctl_t     ctl;
    walker_status_t status [NUM_LAYERS];
    logic           at_end;

    // active walker's end flag back to the timer
    assign at_end = status[ctl.layer_idx].at_end;

    settle_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .state       (state),
        .at_end      (at_end),
        .write_count (write_count),
        .ctl         (ctl)
    );

    // one walker per layer: conv3, fc1, fc2
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        fc_layer_walker #(
            .CFG (LAYER_CFG[i])
        ) u_walker (
            .clk    (clk),
            .rst_n  (rst_n),
            .enable (ctl.enable[i]),
            .hold   (ctl.hold),
            .write  (ctl.write),
            .status (status[i])
        );
    end

    sram_addr_gen u_addr_gen (
        .ctl          (ctl),
        .status       (status),
        .act_port0    (act_port0),
        .act_addr1    (act_addr1),
        .weight_addr0 (weight_addr0),
        .weight_addr1 (weight_addr1),
        .store_case   (store_case),
        .change_state (change_state)
    );

endmodule

`default_nettype wire

/* rtl/fc_addr_pkg.sv */
`default_nettype none

package fc_addr_pkg;

    // state codes match the top-level sequencer
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        CONV1 = 3'd1, // not handled here, same as idle
        CONV2 = 3'd2, // not handled here, same as idle
        CONV3 = 3'd3,
        FC1   = 3'd4,
        FC2   = 3'd5,
        DONE  = 3'd6
    } layer_state_t;

    localparam int         NUM_LAYERS = 3;
    localparam logic [4:0] LAST_CYCLE = 5'd10; // settle count of the write cycle

    typedef logic [15:0] sram_addr_t;

    localparam sram_addr_t BIAS_BASE = 16'd15750; // fc2 bias words in weight sram

    typedef struct packed {
        sram_addr_t act_rd_base;
        sram_addr_t act_wr_base;
        sram_addr_t weight_base;
        logic [6:0] in_last;       // last read position, even
        logic [6:0] out_last;      // last output neuron
        logic [6:0] weight_stride; // weight words per neuron
        logic       packed_lanes;  // four results per word
    } layer_cfg_t;

    // index 0 conv3, 1 fc1, 2 fc2
    localparam layer_cfg_t LAYER_CFG [NUM_LAYERS] = '{
        '{act_rd_base: 16'd592, act_wr_base: 16'd692, weight_base: 16'd1020,
          in_last: 7'd98, out_last: 7'd119, weight_stride: 7'd100, packed_lanes: 1'b1},
        '{act_rd_base: 16'd692, act_wr_base: 16'd722, weight_base: 16'd13020,
          in_last: 7'd28, out_last: 7'd83, weight_stride: 7'd30, packed_lanes: 1'b1},
        '{act_rd_base: 16'd722, act_wr_base: 16'd743, weight_base: 16'd15540,
          in_last: 7'd20, out_last: 7'd9, weight_stride: 7'd21, packed_lanes: 1'b0}
    };

    typedef struct packed {
        logic [3:0] wea;
        sram_addr_t addr;
    } act_port_t;

    typedef struct packed {
        logic [6:0] raddr;
        logic [6:0] neuron;
        logic [1:0] lane;
        logic [4:0] waddr;
        logic       at_end; // raddr sits at in_last
    } walker_status_t;

    typedef struct packed {
        logic [NUM_LAYERS-1:0] enable; // one-hot per walker
        logic [1:0]            layer_idx;
        logic                  active;
        logic                  hold;
        logic                  write;
    } timer_ctl_t;

endpackage

`default_nettype wire

/* rtl/fc_layer_walker.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_layer_walker import fc_addr_pkg::*; #(
    parameter layer_cfg_t CFG = LAYER_CFG[0]
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            enable,
    input  wire            hold,
    input  wire            write,
    output walker_status_t status
);

    logic [6:0] raddr;  // read position inside the input vector
    logic [6:0] neuron; // current output neuron
    logic [1:0] lane;   // byte lane of the next result
    logic [4:0] waddr;  // word of the next result
    logic       at_end;
    logic       last_neuron;

    assign at_end      = (raddr == CFG.in_last);
    assign last_neuron = (neuron == CFG.out_last);

    // two words per cycle, one from each activation port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raddr <= '0;
        end else if (enable) begin
            if (write) begin
                raddr <= '0;
            end else if (!hold && !at_end) begin
                raddr <= raddr + 7'd2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            neuron <= '0;
            lane   <= '0;
            waddr  <= '0;
        end else if (enable && write) begin
            if (last_neuron) begin
                // layer finished, next pass starts clean
                neuron <= '0;
                lane   <= '0;
                waddr  <= '0;
            end else begin
                neuron <= neuron + 7'd1;
                if (CFG.packed_lanes) begin
                    lane <= lane + 2'd1; // wraps after lane 3
                    if (lane == 2'd3) begin
                        waddr <= waddr + 5'd1;
                    end
                end else begin
                    waddr <= waddr + 5'd1; // whole word per result
                end
            end
        end
    end

    assign status = '{
        raddr:  raddr,
        neuron: neuron,
        lane:   lane,
        waddr:  waddr,
        at_end: at_end
    };

endmodule

`default_nettype wire

/* rtl/settle_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module settle_timer import fc_addr_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          layer_state_t state,
    input  wire          at_end,
    output logic [4:0]   write_count,
    output timer_ctl_t   ctl
);

    // layer decode and strobes, all from this cycle's count
    always_comb begin
        ctl = '0;
        case (state)
            CONV3: begin
                ctl.layer_idx = 2'd0;
                ctl.enable[0] = 1'b1;
            end
            FC1: begin
                ctl.layer_idx = 2'd1;
                ctl.enable[1] = 1'b1;
            end
            FC2: begin
                ctl.layer_idx = 2'd2;
                ctl.enable[2] = 1'b1;
            end
            default: ; // idle, conv1, conv2, done
        endcase
        ctl.active = |ctl.enable;
        ctl.write  = (write_count == LAST_CYCLE);
        // inputs exhausted, wait for the datapath to settle
        ctl.hold   = ctl.active && at_end && !ctl.write;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_count <= '0;
        end else if (ctl.write) begin
            write_count <= '0; // one write cycle, then restart
        end else if (ctl.hold) begin
            write_count <= write_count + 5'd1;
        end
    end

endmodule

`default_nettype wire

/* rtl/sram_addr_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module sram_addr_gen import fc_addr_pkg::*; (
    input  wire            timer_ctl_t ctl,
    input  wire            walker_status_t status [NUM_LAYERS],
    output act_port_t      act_port0,
    output sram_addr_t     act_addr1,
    output sram_addr_t     weight_addr0,
    output sram_addr_t     weight_addr1,
    output logic [2:0]     store_case,
    output logic           change_state
);

    walker_status_t sel;
    layer_cfg_t     cfg;

    assign sel = status[ctl.layer_idx];
    assign cfg = LAYER_CFG[ctl.layer_idx];

    always_comb begin
        act_port0    = '0;
        act_addr1    = '0;
        weight_addr0 = '0;
        weight_addr1 = '0;
        store_case   = 3'd0;
        change_state = 1'b0;
        if (ctl.active) begin
            weight_addr0 = sram_addr_t'(sel.raddr)
                         + sram_addr_t'(sel.neuron) * sram_addr_t'(cfg.weight_stride)
                         + cfg.weight_base;
            // fc2 is the only unpacked layer, its bias comes in on port 1
            if (!cfg.packed_lanes && ctl.hold) begin
                weight_addr1 = BIAS_BASE + sram_addr_t'(sel.neuron);
            end else begin
                weight_addr1 = weight_addr0 + 16'd1;
            end

            if (ctl.write) begin
                act_port0.addr = sram_addr_t'(sel.waddr) + cfg.act_wr_base;
                change_state   = (sel.neuron == cfg.out_last);
                if (cfg.packed_lanes) begin
                    case (sel.lane)
                        2'd0: begin
                            act_port0.wea = 4'b0001;
                            store_case    = 3'd4;
                        end
                        2'd1: begin
                            act_port0.wea = 4'b0010;
                            store_case    = 3'd3;
                        end
                        2'd2: begin
                            act_port0.wea = 4'b0100;
                            store_case    = 3'd5;
                        end
                        default: begin
                            act_port0.wea = 4'b1000;
                            store_case    = 3'd6;
                        end
                    endcase
                end else begin
                    act_port0.wea = 4'b1111; // full word
                    store_case    = 3'd4;
                end
            end else begin
                act_port0.addr = sram_addr_t'(sel.raddr) + cfg.act_rd_base;
                act_addr1      = act_port0.addr + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/fc_addr_ctl_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_addr_ctl_checker import fc_addr_pkg::*; (
    input wire               clk,
    input wire               rst_n,
    input wire layer_state_t state,
    input wire act_port_t    act_port0,
    input wire [4:0]         write_count,
    input wire               change_state
);

    int fail_count = 0; // failed assertions so far

    // one pulse per finished layer
    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) change_state |=> !change_state
    ) else begin
        fail_count++;
        $error("change_state high in two consecutive cycles");
    end

    a_wea_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
            (act_port0.wea != 4'b0000) |-> (write_count == LAST_CYCLE)
    ) else begin
        fail_count++;
        $error("wea set outside the write cycle");
    end

    // no writes outside the fc layers
    a_wea_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
            !(state inside {CONV3, FC1, FC2}) |-> (act_port0.wea == 4'b0000)
    ) else begin
        fail_count++;
        $error("wea set while no layer is active");
    end

endmodule

bind fc_addr_ctl fc_addr_ctl_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .state        (state),
    .act_port0    (act_port0),
    .write_count  (write_count),
    .change_state (change_state)
);

`default_nettype wire

/* verif/fc_addr_ctl_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fc_addr_ctl_tb import fc_addr_pkg::*; ();

    typedef struct packed {
        act_port_t  act_port0;
        sram_addr_t act_addr1;
        sram_addr_t weight_addr0;
        sram_addr_t weight_addr1;
        logic [4:0] write_count;
        logic [2:0] store_case;
        logic       change_state;
    } expect_t;

    logic         clk;
    logic         rst_n;
    layer_state_t state;
    act_port_t    act_port0;
    sram_addr_t   act_addr1;
    sram_addr_t   weight_addr0;
    sram_addr_t   weight_addr1;
    logic [4:0]   write_count;
    logic [2:0]   store_case;
    logic         change_state;

    // reference model of the walkers and the settle count
    int m_raddr  [NUM_LAYERS];
    int m_neuron [NUM_LAYERS];
    int m_lane   [NUM_LAYERS];
    int m_waddr  [NUM_LAYERS];
    int m_count;

    int          err_port;
    int          err_addr;
    int          err_field;
    int          err_seq;
    int          err_assert;
    bit          timed_out;
    logic [31:0] lcg_state;

    fc_addr_ctl u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .act_port0    (act_port0),
        .act_addr1    (act_addr1),
        .weight_addr0 (weight_addr0),
        .weight_addr1 (weight_addr1),
        .write_count  (write_count),
        .store_case   (store_case),
        .change_state (change_state)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int layer_index(layer_state_t st);
        case (st)
            CONV3:   return 0;
            FC1:     return 1;
            FC2:     return 2;
            default: return -1; // idle, conv1, conv2, done
        endcase
    endfunction

    function automatic layer_state_t layer_state(int li);
        case (li)
            0:       return CONV3;
            1:       return FC1;
            default: return FC2;
        endcase
    endfunction

    // layer length in cycles up to and including change_state
    function automatic int layer_cycles(int li);
        case (li)
            0:       return 7200;
            1:       return 2100;
            default: return 210;
        endcase
    endfunction

    function automatic logic [2:0] lane_code(int lane);
        case (lane)
            0:       return 3'd4;
            1:       return 3'd3;
            2:       return 3'd5;
            default: return 3'd6;
        endcase
    endfunction

    function automatic expect_t expected_outputs(layer_state_t st);
        expect_t    e;
        layer_cfg_t c;
        int         li;
        bit         at_end;
        bit         wr;
        e = '0;
        e.write_count = 5'(m_count);
        li = layer_index(st);
        if (li >= 0) begin
            c = LAYER_CFG[li];
            at_end = (m_raddr[li] == int'(c.in_last));
            wr = (m_count == int'(LAST_CYCLE));
            e.weight_addr0 = sram_addr_t'(int'(c.weight_base)
                + m_neuron[li] * int'(c.weight_stride) + m_raddr[li]);
            if (li == 2 && at_end && !wr) begin
                e.weight_addr1 = sram_addr_t'(int'(BIAS_BASE) + m_neuron[li]);
            end else begin
                e.weight_addr1 = e.weight_addr0 + 16'd1;
            end
            if (wr) begin
                e.act_port0.addr = sram_addr_t'(int'(c.act_wr_base) + m_waddr[li]);
                e.change_state = (m_neuron[li] == int'(c.out_last));
                if (c.packed_lanes) begin
                    e.act_port0.wea = 4'b0001 << m_lane[li];
                    e.store_case = lane_code(m_lane[li]);
                end else begin
                    e.act_port0.wea = 4'b1111;
                    e.store_case = 3'd4;
                end
            end else begin
                e.act_port0.addr = sram_addr_t'(int'(c.act_rd_base) + m_raddr[li]);
                e.act_addr1 = e.act_port0.addr + 16'd1;
            end
        end
        return e;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < NUM_LAYERS; i++) begin
            m_raddr[i] = 0;
            m_neuron[i] = 0;
            m_lane[i] = 0;
            m_waddr[i] = 0;
        end
        m_count = 0;
    endtask

    // state of the model after the coming rising edge
    task automatic advance_model(layer_state_t st);
        layer_cfg_t c;
        int         li;
        li = layer_index(st);
        if (m_count == int'(LAST_CYCLE)) begin
            m_count = 0;
            if (li >= 0) begin
                c = LAYER_CFG[li];
                m_raddr[li] = 0;
                if (m_neuron[li] == int'(c.out_last)) begin
                    m_neuron[li] = 0;
                    m_lane[li] = 0;
                    m_waddr[li] = 0;
                end else begin
                    m_neuron[li]++;
                    if (!c.packed_lanes) begin
                        m_waddr[li]++;
                    end else if (m_lane[li] == 3) begin
                        m_lane[li] = 0;
                        m_waddr[li]++;
                    end else begin
                        m_lane[li]++;
                    end
                end
            end
        end else if (li >= 0) begin
            if (m_raddr[li] == int'(LAYER_CFG[li].in_last)) begin
                m_count++; // settling
            end else begin
                m_raddr[li] += 2;
            end
        end
    endtask

    task automatic check_port(input string what, input act_port_t got, input act_port_t want);
        if (got !== want) begin
            err_port++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_addr(input string what, input sram_addr_t got, input sram_addr_t want);
        if (got !== want) begin
            err_addr++;
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_field(input string what, input logic [4:0] got, input logic [4:0] want);
        if (got !== want) begin
            err_field++;
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (!rst_n) begin
            reset_model();
        end else begin
            e = expected_outputs(state);
            check_port("act_port0", act_port0, e.act_port0);
            check_addr("act_addr1", act_addr1, e.act_addr1);
            check_addr("weight_addr0", weight_addr0, e.weight_addr0);
            check_addr("weight_addr1", weight_addr1, e.weight_addr1);
            check_field("store_case", {2'b00, store_case}, {2'b00, e.store_case});
            check_field("write_count", write_count, e.write_count);
            check_field("change_state", {4'b0000, change_state}, {4'b0000, e.change_state});
            advance_model(state);
        end
    end

    task automatic drive_state(input layer_state_t st);
        @(posedge clk);
        #1 state = st;
    endtask

    task automatic run_layer(input int li);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        drive_state(layer_state(li));
        while (!seen && cycles < 2 * layer_cycles(li)) begin
            @(negedge clk);
            cycles++;
            if (change_state === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            err_seq++;
            timed_out = 1'b1;
            $display("timeout: layer %0d gave no change_state within %0d cycles", li, cycles);
        end else if (cycles != layer_cycles(li)) begin
            err_seq++;
            $display("** Error at %0t ns: layer %0d took %0d cycles expected %0d",
                     $time, li, cycles, layer_cycles(li));
        end
    endtask

    initial begin
        int gap;
        err_port = 0;
        err_addr = 0;
        err_field = 0;
        err_seq = 0;
        err_assert = 0;
        timed_out = 1'b0;
        lcg_state = 32'h2aba;
        state = IDLE;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (4) @(posedge clk); // idle outputs stay zero
        for (int pass = 0; pass < 2 && !timed_out; pass++) begin
            for (int li = 0; li < NUM_LAYERS && !timed_out; li++) begin
                gap = int'((lcg_next() >> 16) % 8);
                if (gap > 0) begin
                    drive_state(IDLE);
                    repeat (gap - 1) @(posedge clk);
                end
                run_layer(li);
            end
        end
        drive_state(IDLE);
        repeat (5) @(posedge clk);
        err_assert = u_dut.u_checker.fail_count;
        $display("errors: port %0d, address %0d, field %0d, sequence %0d, assertion %0d",
                 err_port, err_addr, err_field, err_seq, err_assert);
        if (err_port + err_addr + err_field + err_seq + err_assert == 0
                && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
